//--- rv_isa_pkg.sv
// rv32i/rv32m facts only; compressed words must already be expanded before decode
package rv_isa_pkg;

  localparam int XLEN          = 32;
  localparam int REG_AW        = 5;
  localparam int CAP_REG_LIMIT = 16;    // capability mode only sees x0..x15

  localparam bit RV32M_EN = 1'b1;       // mul/div present

  // bit positions inside the instruction word
  localparam int RD_LSB    = 7;
  localparam int F3_LSB    = 12;
  localparam int RS1_LSB   = 15;
  localparam int RS2_LSB   = 20;
  localparam int F7_LSB    = 25;
  localparam int IMM_I_LSB = 20;

  typedef enum logic [6:0] {
    OPCODE_LOAD     = 7'h03,
    OPCODE_MISC_MEM = 7'h0f,
    OPCODE_OP_IMM   = 7'h13,
    OPCODE_AUIPC    = 7'h17,
    OPCODE_STORE    = 7'h23,
    OPCODE_OP       = 7'h33,
    OPCODE_LUI      = 7'h37,
    OPCODE_BRANCH   = 7'h63,
    OPCODE_JALR     = 7'h67,
    OPCODE_JAL      = 7'h6f,
    OPCODE_SYSTEM   = 7'h73
  } opcode_e;

  localparam logic [6:0] F7_BASE   = 7'h00;
  localparam logic [6:0] F7_ALT    = 7'h20;  // sub, sra, srai
  localparam logic [6:0] F7_MULDIV = 7'h01;

  localparam logic [2:0] FUNCT3_CAP = 3'b011;  // clc / csc width

  // funct3 == 0 system immediates
  localparam logic [11:0] SYS_ECALL  = 12'h000;
  localparam logic [11:0] SYS_EBREAK = 12'h001;
  localparam logic [11:0] SYS_MRET   = 12'h302;
  localparam logic [11:0] SYS_WFI    = 12'h105;

endpackage

//--- dec_pkg.sv
// decode-stage payloads; pcc top is 33 bits so the full 4 GiB space can be described
package dec_pkg;
  import rv_isa_pkg::*;

  localparam int OTYPE_W = 4;

  typedef enum logic [2:0] {
    PL_ALU   = 3'd0,
    PL_MULT  = 3'd1,
    PL_LS    = 3'd2,
    PL_JAL   = 3'd3,
    PL_JALR  = 3'd4,
    PL_LOCAL = 3'd5   // handled inside the issue stage
  } pl_type_e;

  typedef struct packed {
    logic [XLEN-1:0]    base;
    logic [XLEN:0]      top;
    logic               perm_ex;
    logic               perm_sr;
    logic               valid;
    logic [OTYPE_W-1:0] otype;
  } pcc_cap_t;

  // fetched item
  typedef struct packed {
    logic [XLEN-1:0] insn;
    logic [XLEN-1:0] pc;
    logic            is_comp;
    logic            fetch_err;
    logic            cheri_pmode;
    logic            debug_mode;
    pcc_cap_t        pcc;
  } ir_reg_t;

  typedef struct packed {
    logic valid;   // any of the flags below
    logic csrw;
    logic mret;
    logic wfi;
    logic ebrk;
    logic ecall;
    logic fencei;
  } sysctl_t;

  typedef struct packed {
    logic illegal_insn;
    logic perm_vio;
    logic bound_vio;
    logic fetch_err;
  } dec_errs_t;

  // decoded item
  typedef struct packed {
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic [REG_AW-1:0] rd;
    logic [1:0]        rf_ren;   // {b, a}
    logic              rf_we;
    pl_type_e          pl_type;
    logic              is_branch;
    logic              is_jal;
    logic              is_jalr;
    logic [XLEN-1:0]   btarget;
    logic [XLEN-1:0]   pc_nxt;
    sysctl_t           sysctl;
    dec_errs_t         errs;
    logic              any_err;
  } ir_dec_t;

endpackage

//--- dec_stream_if.sv
// valid/ready link; source must hold valid and data stable until ready is seen
`timescale 1ns/100ps

interface dec_stream_if #(
  parameter type payload_t = logic
) ();

  logic     valid;
  logic     ready;
  payload_t data;

  modport source (
    output valid,
    output data,
    input  ready
  );

  modport sink (
    input  valid,
    input  data,
    output ready
  );

endinterface

//--- stream_reg.sv
// single-entry slot; ready is combinational from downstream ready, so long chains add ready depth
`timescale 1ns/100ps

module stream_reg #(
  parameter type payload_t = logic
) (
  input  logic         clk_i,
  input  logic         rst_n_i,
  dec_stream_if.sink   up,
  dec_stream_if.source dn
);

  logic     full_q;
  payload_t data_q;
  logic     up_xfer;

  // empty slot, or the current item leaves this cycle
  assign up.ready = ~full_q | dn.ready;
  assign up_xfer  = up.valid & up.ready;

  assign dn.valid = full_q;
  assign dn.data  = data_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      full_q <= 1'b0;
    end else if (up_xfer) begin
      full_q <= 1'b1;          // load or refill
    end else if (dn.ready) begin
      full_q <= 1'b0;          // drained with nothing new
    end
  end

  always_ff @(posedge clk_i) begin
    if (up_xfer) begin
      data_q <= up.data;
    end
  end

endmodule

//--- instr_classifier.sv
// rv32i/rv32m only; bitmanip, atomics and capability opcodes all decode as illegal
`timescale 1ns/100ps

module instr_classifier import rv_isa_pkg::*; import dec_pkg::*; (
  input  logic [XLEN-1:0] insn_i,
  input  logic            cheri_pmode_i,
  output pl_type_e        pl_type_o,
  output logic            rf_ren_a_o,
  output logic            rf_ren_b_o,
  output logic            rf_we_o,
  output logic            illegal_insn_o,
  output sysctl_t         sysctl_o
);

  opcode_e           opcode;
  logic [2:0]        funct3;
  logic [6:0]        funct7;
  logic [REG_AW-1:0] rs1, rs2, rd;
  pl_type_e          pl_type;
  logic              ren_a, ren_b, we;
  logic              illegal_enc, illegal_reg;
  logic              csr_wr, mret, wfi, ebrk, ecall, fencei;

  assign opcode = opcode_e'(insn_i[6:0]);
  assign funct3 = insn_i[F3_LSB +: 3];
  assign funct7 = insn_i[F7_LSB +: 7];
  assign rs1    = insn_i[RS1_LSB +: REG_AW];
  assign rs2    = insn_i[RS2_LSB +: REG_AW];
  assign rd     = insn_i[RD_LSB +: REG_AW];

  //////////////////////////////////////////////////
  // opcode decode
  //////////////////////////////////////////////////

  always_comb begin
    pl_type     = PL_ALU;
    ren_a       = 1'b0;
    ren_b       = 1'b0;
    we          = 1'b0;
    illegal_enc = 1'b0;
    csr_wr      = 1'b0;
    mret        = 1'b0;
    wfi         = 1'b0;
    ebrk        = 1'b0;
    ecall       = 1'b0;
    fencei      = 1'b0;

    unique case (opcode)
      OPCODE_JAL: begin
        pl_type = PL_JAL;
        we      = 1'b1;
      end
      OPCODE_JALR: begin
        pl_type     = PL_JALR;
        ren_a       = 1'b1;
        we          = 1'b1;
        illegal_enc = (funct3 != 3'b000);
      end
      OPCODE_BRANCH: begin
        pl_type     = PL_LOCAL;
        ren_a       = 1'b1;
        ren_b       = 1'b1;
        illegal_enc = (funct3[2:1] == 2'b01);   // 010 / 011 unused
      end
      OPCODE_LOAD: begin
        pl_type     = PL_LS;
        ren_a       = 1'b1;
        we          = 1'b1;
        illegal_enc = (funct3[2:1] == 2'b11) | (~cheri_pmode_i & (funct3 == FUNCT3_CAP));
      end
      OPCODE_STORE: begin
        pl_type     = PL_LS;
        ren_a       = 1'b1;
        ren_b       = 1'b1;
        illegal_enc = funct3[2] | (~cheri_pmode_i & (funct3 == FUNCT3_CAP));
      end
      OPCODE_LUI, OPCODE_AUIPC: begin
        we = 1'b1;
      end
      OPCODE_OP_IMM: begin
        ren_a = 1'b1;
        we    = 1'b1;
        if (funct3 == 3'b001) begin            // slli
          illegal_enc = (funct7 != F7_BASE);
        end else if (funct3 == 3'b101) begin   // srli / srai
          illegal_enc = (funct7 != F7_BASE) && (funct7 != F7_ALT);
        end
      end
      OPCODE_OP: begin
        ren_a = 1'b1;
        ren_b = 1'b1;
        we    = 1'b1;
        if (funct7 == F7_MULDIV) begin
          pl_type     = PL_MULT;
          illegal_enc = ~RV32M_EN;
        end else if (funct7 == F7_ALT) begin
          illegal_enc = (funct3 != 3'b000) && (funct3 != 3'b101);  // sub, sra
        end else begin
          illegal_enc = (funct7 != F7_BASE);
        end
      end
      OPCODE_MISC_MEM: begin
        pl_type     = PL_LOCAL;
        fencei      = (funct3 == 3'b001);
        illegal_enc = (funct3[2:1] != 2'b00);  // fence is a nop
      end
      OPCODE_SYSTEM: begin
        if (funct3 == 3'b000) begin
          pl_type = PL_LOCAL;
          unique case (insn_i[XLEN-1:IMM_I_LSB])
            SYS_ECALL:  ecall = 1'b1;
            SYS_EBREAK: ebrk  = 1'b1;
            SYS_MRET:   mret  = 1'b1;
            SYS_WFI:    wfi   = 1'b1;
            default:    illegal_enc = 1'b1;
          endcase
          if (rs1 != '0 || rd != '0) begin
            illegal_enc = 1'b1;
          end
        end else begin
          // csr set/clear with x0 only reads
          pl_type     = PL_MULT;
          ren_a       = ~funct3[2];
          we          = 1'b1;
          csr_wr      = ~(funct3[1] && (rs1 == '0));
          illegal_enc = (funct3[1:0] == 2'b00);
        end
      end
      default: begin
        illegal_enc = 1'b1;
      end
    endcase
  end

  // upper half of the register file is not there in capability mode
  assign illegal_reg = cheri_pmode_i & ((ren_a & (rs1 >= CAP_REG_LIMIT)) |
                                        (ren_b & (rs2 >= CAP_REG_LIMIT)) |
                                        (we & (rd >= CAP_REG_LIMIT)));

  assign pl_type_o      = pl_type;
  assign rf_ren_a_o     = ren_a & ~illegal_reg;
  assign rf_ren_b_o     = ren_b & ~illegal_reg;
  assign rf_we_o        = we & ~illegal_reg;
  assign illegal_insn_o = illegal_enc | illegal_reg;

  assign sysctl_o.valid  = csr_wr | mret | wfi | ebrk | ecall | fencei;
  assign sysctl_o.csrw   = csr_wr;
  assign sysctl_o.mret   = mret;
  assign sysctl_o.wfi    = wfi;
  assign sysctl_o.ebrk   = ebrk;
  assign sysctl_o.ecall  = ecall;
  assign sysctl_o.fencei = fencei;

endmodule

//--- fetch_check.sv
// checks the fetch against pcc only; flags are forced low outside capability mode and in debug
`timescale 1ns/100ps

module fetch_check import rv_isa_pkg::*; import dec_pkg::*; (
  input  logic [XLEN-1:0] pc_i,
  input  logic            is_comp_i,
  input  logic            cheri_pmode_i,
  input  logic            debug_mode_i,
  input  pcc_cap_t        pcc_i,
  input  logic            mret_i,
  output logic            bound_vio_o,
  output logic            perm_vio_o
);

  logic [XLEN+1:0] hdrm;
  logic            hdrm_ge4, hdrm_ge2, hdrm_ok, base_ok;
  logic            all_space, chk_en;

  // whole address space lets pc 0xffff_fffe fetch a full word across the wrap
  assign all_space = (pcc_i.base == '0) & pcc_i.top[XLEN];

  assign hdrm     = {1'b0, pcc_i.top} - {2'b00, pc_i};
  assign hdrm_ge4 = ~hdrm[XLEN+1] & (|hdrm[XLEN:2]);
  assign hdrm_ge2 = ~hdrm[XLEN+1] & (|hdrm[XLEN:1]);
  assign hdrm_ok  = all_space | (is_comp_i ? hdrm_ge2 : hdrm_ge4);
  assign base_ok  = (pc_i >= pcc_i.base);

  assign chk_en = cheri_pmode_i & ~debug_mode_i;

  assign bound_vio_o = chk_en & (~base_ok | ~hdrm_ok);
  assign perm_vio_o  = chk_en & (~pcc_i.perm_ex | ~pcc_i.valid | (pcc_i.otype != '0) |
                                 (mret_i & ~pcc_i.perm_sr));

endmodule

//--- dec_unit.sv
// purely combinational between two slots; handshake is passed straight through
`timescale 1ns/100ps

module dec_unit import rv_isa_pkg::*; import dec_pkg::*; (
  dec_stream_if.sink   up,
  dec_stream_if.source dn
);

  ir_reg_t         ir;
  opcode_e         opcode;
  pl_type_e        pl_type;
  logic            ren_a, ren_b, we;
  logic            illegal, perm_vio, bound_vio;
  sysctl_t         sysctl;
  dec_errs_t       errs;
  logic [XLEN-1:0] imm_j, imm_b;

  assign up.ready = dn.ready;
  assign dn.valid = up.valid;

  assign ir     = up.data;
  assign opcode = opcode_e'(ir.insn[6:0]);

  instr_classifier u_cls (
    .insn_i         (ir.insn),
    .cheri_pmode_i  (ir.cheri_pmode),
    .pl_type_o      (pl_type),
    .rf_ren_a_o     (ren_a),
    .rf_ren_b_o     (ren_b),
    .rf_we_o        (we),
    .illegal_insn_o (illegal),
    .sysctl_o       (sysctl)
  );

  fetch_check u_fchk (
    .pc_i          (ir.pc),
    .is_comp_i     (ir.is_comp),
    .cheri_pmode_i (ir.cheri_pmode),
    .debug_mode_i  (ir.debug_mode),
    .pcc_i         (ir.pcc),
    .mret_i        (sysctl.mret),
    .bound_vio_o   (bound_vio),
    .perm_vio_o    (perm_vio)
  );

  assign imm_j = {{12{ir.insn[31]}}, ir.insn[19:12], ir.insn[20], ir.insn[30:21], 1'b0};
  assign imm_b = {{20{ir.insn[31]}}, ir.insn[7], ir.insn[30:25], ir.insn[11:8], 1'b0};

  assign errs.illegal_insn = illegal;
  assign errs.perm_vio     = perm_vio;
  assign errs.bound_vio    = bound_vio;
  assign errs.fetch_err    = ir.fetch_err;

  // unused register fields read as zero
  assign dn.data.rs1 = ren_a ? ir.insn[RS1_LSB +: REG_AW] : '0;
  assign dn.data.rs2 = ren_b ? ir.insn[RS2_LSB +: REG_AW] : '0;
  assign dn.data.rd  = we ? ir.insn[RD_LSB +: REG_AW] : '0;

  assign dn.data.rf_ren    = {ren_b, ren_a};
  assign dn.data.rf_we     = we;
  assign dn.data.pl_type   = pl_type;
  assign dn.data.is_branch = (opcode == OPCODE_BRANCH);
  assign dn.data.is_jal    = (opcode == OPCODE_JAL);
  assign dn.data.is_jalr   = (opcode == OPCODE_JALR);
  assign dn.data.btarget   = ir.pc + ((opcode == OPCODE_JAL) ? imm_j : imm_b);
  assign dn.data.pc_nxt    = ir.pc + (ir.is_comp ? 32'd2 : 32'd4);   // wraps at 4 GiB
  assign dn.data.sysctl    = sysctl;
  assign dn.data.errs      = errs;
  assign dn.data.any_err   = |errs;

endmodule

//--- decode_stage.sv
// two-slot decode stage; in_ready_o depends combinationally on out_ready_i
`timescale 1ns/100ps

module decode_stage import rv_isa_pkg::*; import dec_pkg::*; (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  // fetch side
  input  logic                         in_valid_i,
  output logic                         in_ready_o,
  input  logic [XLEN-1:0]              insn_i,
  input  logic [XLEN-1:0]              pc_i,
  input  logic                         is_comp_i,
  input  logic                         fetch_err_i,
  input  logic                         cheri_pmode_i,
  input  logic                         debug_mode_i,
  input  logic [XLEN-1:0]              pcc_base_i,
  input  logic [XLEN:0]                pcc_top_i,
  input  logic                         pcc_perm_ex_i,
  input  logic                         pcc_perm_sr_i,
  input  logic                         pcc_valid_i,
  input  logic [OTYPE_W-1:0]           pcc_otype_i,
  // issue side
  output logic                         out_valid_o,
  input  logic                         out_ready_i,
  output logic [REG_AW-1:0]            rs1_o,
  output logic [REG_AW-1:0]            rs2_o,
  output logic [REG_AW-1:0]            rd_o,
  output logic [1:0]                   rf_ren_o,
  output logic                         rf_we_o,
  output logic [2:0]                   pl_type_o,
  output logic                         is_branch_o,
  output logic                         is_jal_o,
  output logic                         is_jalr_o,
  output logic [XLEN-1:0]              btarget_o,
  output logic [XLEN-1:0]              pc_nxt_o,
  output logic [$bits(sysctl_t)-1:0]   sysctl_o,
  output logic [$bits(dec_errs_t)-1:0] errs_o,
  output logic                         any_err_o
);

  dec_stream_if #(.payload_t(ir_reg_t)) ir_in_if ();
  dec_stream_if #(.payload_t(ir_reg_t)) ir_q_if ();
  dec_stream_if #(.payload_t(ir_dec_t)) dec_d_if ();
  dec_stream_if #(.payload_t(ir_dec_t)) dec_q_if ();

  //////////////////////////////////////////////////
  // pack fetch side
  //////////////////////////////////////////////////

  assign ir_in_if.valid = in_valid_i;
  assign in_ready_o     = ir_in_if.ready;
  assign ir_in_if.data  = '{insn: insn_i, pc: pc_i, is_comp: is_comp_i, fetch_err: fetch_err_i,
                            cheri_pmode: cheri_pmode_i, debug_mode: debug_mode_i,
                            pcc: '{base: pcc_base_i, top: pcc_top_i, perm_ex: pcc_perm_ex_i,
                                   perm_sr: pcc_perm_sr_i, valid: pcc_valid_i,
                                   otype: pcc_otype_i}};

  stream_reg #(.payload_t(ir_reg_t)) u_in_slot (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .up      (ir_in_if),
    .dn      (ir_q_if)
  );

  dec_unit u_dec (
    .up (ir_q_if),
    .dn (dec_d_if)
  );

  stream_reg #(.payload_t(ir_dec_t)) u_out_slot (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .up      (dec_d_if),
    .dn      (dec_q_if)
  );

  //////////////////////////////////////////////////
  // unpack issue side
  //////////////////////////////////////////////////

  assign dec_q_if.ready = out_ready_i;
  assign out_valid_o    = dec_q_if.valid;

  assign rs1_o       = dec_q_if.data.rs1;
  assign rs2_o       = dec_q_if.data.rs2;
  assign rd_o        = dec_q_if.data.rd;
  assign rf_ren_o    = dec_q_if.data.rf_ren;
  assign rf_we_o     = dec_q_if.data.rf_we;
  assign pl_type_o   = dec_q_if.data.pl_type;
  assign is_branch_o = dec_q_if.data.is_branch;
  assign is_jal_o    = dec_q_if.data.is_jal;
  assign is_jalr_o   = dec_q_if.data.is_jalr;
  assign btarget_o   = dec_q_if.data.btarget;
  assign pc_nxt_o    = dec_q_if.data.pc_nxt;
  assign sysctl_o    = dec_q_if.data.sysctl;   // {valid, csrw, mret, wfi, ebrk, ecall, fencei}
  assign errs_o      = dec_q_if.data.errs;     // {illegal, perm, bound, fetch}
  assign any_err_o   = dec_q_if.data.any_err;

endmodule

//--- decode_stage_asserts.sv
// output handshake rules only; payload is the flat output bus of decode_stage, 100 bits
`timescale 1ns/100ps

module decode_stage_asserts (
  input logic        clk_i,
  input logic        rst_n_i,
  input logic        out_valid_i,
  input logic        out_ready_i,
  input logic [99:0] payload_i
);

  // nothing leaves the stage while reset is held
  a_no_valid_in_reset : assert property (@(posedge clk_i) !rst_n_i |-> !out_valid_i)
    else $error("out_valid_o high during reset");

  a_valid_held : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_i && !out_ready_i |=> out_valid_i)
    else $error("out_valid_o dropped before the transfer");

  a_payload_stable : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_i && !out_ready_i |=> $stable(payload_i))
    else $error("output payload changed during a stall");

endmodule

bind decode_stage decode_stage_asserts u_asserts (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .out_valid_i (out_valid_o),
  .out_ready_i (out_ready_i),
  .payload_i   ({rs1_o, rs2_o, rd_o, rf_ren_o, rf_we_o, pl_type_o, is_branch_o, is_jal_o,
                 is_jalr_o, btarget_o, pc_nxt_o, sysctl_o, errs_o, any_err_o})
);

//--- tb_decode_stage.sv
// expects dec_input.txt in the run directory; 18 hex fields per vector line, # starts a comment
`timescale 1ns/100ps

module tb_decode_stage import rv_isa_pkg::*; ();

  typedef struct {
    logic [31:0] insn;
    logic [31:0] pc;
    logic [3:0]  flg;    // {is_comp, fetch_err, cheri_pmode, debug_mode}
    logic [31:0] base;
    logic [32:0] top;
    logic [2:0]  cap;    // {perm_ex, perm_sr, valid}
    logic [3:0]  otype;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [1:0]  ren;
    logic        we;
    logic [2:0]  pl;
    logic [2:0]  jbj;    // {is_branch, is_jal, is_jalr}
    logic [31:0] btgt;
    logic [31:0] pcn;
    logic [6:0]  sys;
    logic [3:0]  errs;
  } vec_t;

  logic clk_i, rst_n_i;
  logic in_valid_i, in_ready_o, out_valid_o, out_ready_i;
  logic [31:0] insn_i, pc_i, pcc_base_i;
  logic [32:0] pcc_top_i;
  logic is_comp_i, fetch_err_i, cheri_pmode_i, debug_mode_i;
  logic pcc_perm_ex_i, pcc_perm_sr_i, pcc_valid_i;
  logic [3:0] pcc_otype_i;
  logic [4:0] rs1_o, rs2_o, rd_o;
  logic [1:0] rf_ren_o;
  logic rf_we_o, is_branch_o, is_jal_o, is_jalr_o, any_err_o;
  logic [2:0] pl_type_o;
  logic [31:0] btarget_o, pc_nxt_o;
  logic [6:0] sysctl_o;
  logic [3:0] errs_o;

  vec_t vecs[$];
  vec_t exp_q[$];
  vec_t cur;
  int   sent, checked, cycles, limit;

  decode_stage DUT (.*);

  always #5 clk_i = ~clk_i;

  ////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("MISMATCH time=%0t %s expected=%0h actual=%0h", $time, name, exp, act);
      $display("CHECKS FAILED");
      $fatal(1, "stopping at the first wrong value");
    end
  endtask

  task automatic load_vectors();
    int    fd, n;
    string line;
    vec_t  v;
    fd = $fopen("dec_input.txt", "r");
    if (fd == 0) begin
      $display("CHECKS FAILED");
      $fatal(1, "could not open dec_input.txt");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.substr(0, 0) == "#") continue;
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  v.insn, v.pc, v.flg, v.base, v.top, v.cap, v.otype,
                  v.rs1, v.rs2, v.rd, v.ren, v.we, v.pl, v.jbj,
                  v.btgt, v.pcn, v.sys, v.errs);
      if (n != 18) begin
        $display("CHECKS FAILED");
        $fatal(1, "a vector line in dec_input.txt does not hold 18 fields");
      end
      vecs.push_back(v);
    end
    $fclose(fd);
  endtask

  task automatic drive_vector(input vec_t v);
    in_valid_i <= 1'b1;
    insn_i     <= v.insn;
    pc_i       <= v.pc;
    {is_comp_i, fetch_err_i, cheri_pmode_i, debug_mode_i} <= v.flg;
    pcc_base_i <= v.base;
    pcc_top_i  <= v.top;
    {pcc_perm_ex_i, pcc_perm_sr_i, pcc_valid_i} <= v.cap;
    pcc_otype_i <= v.otype;
  endtask

  task automatic compare_outputs(input vec_t e);
    check("rs1_o", 64'(e.rs1), 64'(rs1_o));
    check("rs2_o", 64'(e.rs2), 64'(rs2_o));
    check("rd_o", 64'(e.rd), 64'(rd_o));
    check("rf_ren_o", 64'(e.ren), 64'(rf_ren_o));
    check("rf_we_o", 64'(e.we), 64'(rf_we_o));
    check("pl_type_o", 64'(e.pl), 64'(pl_type_o));
    check("branch/jal/jalr", 64'(e.jbj), 64'({is_branch_o, is_jal_o, is_jalr_o}));
    check("btarget_o", 64'(e.btgt), 64'(btarget_o));
    check("pc_nxt_o", 64'(e.pcn), 64'(pc_nxt_o));
    check("sysctl_o", 64'(e.sys), 64'(sysctl_o));
    check("sysctl_o.valid", 64'(|e.sys[5:0]), 64'(sysctl_o[6]));   // or of the flags
    check("errs_o", 64'(e.errs), 64'(errs_o));
    check("any_err_o", 64'(|e.errs), 64'(any_err_o));
  endtask

  ////////////////////////////////////////////////
  // reset, stimulus and scoreboard
  ////////////////////////////////////////////////

  initial begin
    void'($urandom(44054));
    clk_i         = 1'b0;
    rst_n_i       = 1'b0;
    in_valid_i    = 1'b0;
    out_ready_i   = 1'b0;
    insn_i        = '0;
    pc_i          = '0;
    is_comp_i     = 1'b0;
    fetch_err_i   = 1'b0;
    cheri_pmode_i = 1'b0;
    debug_mode_i  = 1'b0;
    pcc_base_i    = '0;
    pcc_top_i     = '0;
    pcc_perm_ex_i = 1'b0;
    pcc_perm_sr_i = 1'b0;
    pcc_valid_i   = 1'b0;
    pcc_otype_i   = '0;
    sent = 0;
    checked = 0;
    cycles = 0;
    load_vectors();
    if (vecs.size() == 0) begin
      $display("CHECKS FAILED");
      $fatal(1, "dec_input.txt holds no vectors");
    end
    limit = 8 * vecs.size() + 50;
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;
  end

  always @(posedge clk_i) begin
    if (rst_n_i) begin
      cycles = cycles + 1;
      if (in_valid_i && in_ready_o) begin   // transfer at this edge
        exp_q.push_back(vecs[sent]);
        sent = sent + 1;
      end
      if (sent < vecs.size()) begin
        drive_vector(vecs[sent]);
      end else begin
        in_valid_i <= 1'b0;
      end
      if (out_valid_o && out_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("CHECKS FAILED");
          $fatal(1, "an output appeared with no vector outstanding");
        end
        cur = exp_q.pop_front();
        compare_outputs(cur);
        checked = checked + 1;
      end
      out_ready_i <= (($urandom % 4) != 0);   // stall about one cycle in four
      if (checked == vecs.size()) begin
        $display("ALL CHECKS PASSED");
        $finish;
      end else if (cycles > limit) begin
        $display("CHECKS FAILED");
        $fatal(1, "timeout, not every vector came out of the stage");
      end
    end
  end

endmodule

//--- decode_stage.f
rv_isa_pkg.sv
dec_pkg.sv
dec_stream_if.sv
stream_reg.sv
instr_classifier.sv
fetch_check.sv
dec_unit.sv
decode_stage.sv
decode_stage_asserts.sv
tb_decode_stage.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal
TOP       ?= tb_decode_stage
FILELIST  ?= decode_stage.f
OBJDIR    ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the decode_stage testbench"
	@echo "  clean  remove build output"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

//--- dec_input.txt
# insn pc flg{comp,ferr,pmode,dbg} base top cap{ex,sr,valid} otype | expected:
# rs1 rs2 rd ren we pl jbj{br,jal,jalr} btarget pc_nxt sysctl errs{ill,perm,bound,ferr}
002081B3 00000100 0 00000000 100000000 7 0 01 02 03 3 1 0 0 00000902 00000104 00 0
027302B3 00000200 0 00000000 100000000 7 0 06 07 05 3 1 1 0 00000A24 00000204 00 0
FFF58513 00000300 0 00000000 100000000 7 0 0B 00 0A 1 1 0 0 FFFFFAEA 00000304 00 0
00812203 00000400 0 00000000 100000000 7 0 02 00 04 1 1 2 0 00000404 00000404 00 0
00532623 00000500 0 00000000 100000000 7 0 06 05 00 3 0 2 0 0000050C 00000504 00 0
00208863 00000600 0 00000000 100000000 7 0 01 02 00 3 0 5 4 00000610 00000604 00 0
001000EF 00000700 8 00000000 100000000 7 0 00 00 01 0 1 3 2 00000F00 00000702 00 0
004280E7 00000800 0 00000000 100000000 7 0 05 00 01 1 1 4 1 00001000 00000804 00 0
123453B7 00000900 0 00000000 100000000 7 0 00 00 07 0 1 0 0 00001226 00000904 00 0
300110F3 00000A00 0 00000000 100000000 7 0 02 00 01 1 1 1 0 00001500 00000A04 60 0
300020F3 00000B00 0 00000000 100000000 7 0 00 00 01 1 1 1 0 00001600 00000B04 00 0
00000073 00000C00 0 00000000 100000000 7 0 00 00 00 0 0 5 0 00000C00 00000C04 42 0
00100073 00000D00 0 00000000 100000000 7 0 00 00 00 0 0 5 0 00000D00 00000D04 44 0
30200073 00000E00 2 00000000 100000000 5 0 00 00 00 0 0 5 0 00001100 00000E04 50 4
10500073 00000F00 0 00000000 100000000 7 0 00 00 00 0 0 5 0 00001000 00000F04 48 0
0000100F 00001000 0 00000000 100000000 7 0 00 00 00 0 0 5 0 00001000 00001004 41 0
000000F3 00001100 0 00000000 100000000 7 0 00 00 00 0 0 5 0 00001900 00001104 42 8
0000007F 00001200 0 00000000 100000000 7 0 00 00 00 0 0 0 0 00001200 00001204 00 8
04000033 00001300 0 00000000 100000000 7 0 00 00 00 3 1 0 0 00001340 00001304 00 8
004290E7 00001400 0 00000000 100000000 7 0 05 00 01 1 1 4 1 00001C00 00001404 00 8
00013203 00001500 0 00000000 100000000 7 0 02 00 04 1 1 2 0 00001504 00001504 00 8
00013203 00001600 2 00000000 100000000 7 0 02 00 04 1 1 2 0 00001604 00001604 00 0
014081B3 00001700 2 00000000 100000000 7 0 00 00 00 0 0 0 0 00001F02 00001704 00 8
002081B3 00001000 2 00001000 000001002 7 0 01 02 03 3 1 0 0 00001802 00001004 00 2
002081B3 00001000 A 00001000 000001002 7 0 01 02 03 3 1 0 0 00001802 00001002 00 0
002081B3 00001F00 2 00002000 000003000 7 0 01 02 03 3 1 0 0 00002702 00001F04 00 2
002081B3 00001800 2 00000000 100000000 3 0 01 02 03 3 1 0 0 00002002 00001804 00 4
002081B3 00001900 3 00000000 100000000 7 3 01 02 03 3 1 0 0 00002102 00001904 00 0
002081B3 FFFFFFFE 2 00000000 100000000 7 0 01 02 03 3 1 0 0 00000800 00000002 00 0
002081B3 00001A00 4 00000000 100000000 7 0 01 02 03 3 1 0 0 00002202 00001A04 00 1
002081B3 00001F00 0 00002000 000003000 0 0 01 02 03 3 1 0 0 00002702 00001F04 00 0
